// ==== source/cpu_types_pkg.sv ====
/*
  Shared types and widths for the execute datapath.
  Compile this package before any interface or module that uses it.
  Opcode values match the numeric codes used in the stimulus data.
*/

package cpu_types_pkg;

	// width of a data word in bits
	localparam int word_w = 32;

	// number of bits needed to select one of the 32 registers
	localparam int reg_w = 5;

	// shifts only honour this many low bits of the shift amount
	localparam int shamt_w = 5;

	// a full data word as held in a register or produced by the alu
	typedef logic [word_w-1:0] word_t;

	// a register number, zero is the hardwired zero register
	typedef logic [reg_w-1:0] regbits_t;

	// alu operation select
	// the encoding is fixed because the stimulus file stores these values directly
	typedef enum logic [3:0] {
		// logical shifts of operand b by operand a
		alu_sll  = 4'd0,
		alu_srl  = 4'd1,
		// signed arithmetic
		alu_add  = 4'd2,
		alu_sub  = 4'd3,
		// bitwise logic
		alu_and  = 4'd4,
		alu_or   = 4'd5,
		alu_xor  = 4'd6,
		alu_nor  = 4'd7,
		// set-less-than, signed then unsigned compare of a against b
		alu_slt  = 4'd8,
		alu_sltu = 4'd9
	} aluop_t;

endpackage

// ==== source/alu_if.sv ====
/*
  Bundle between the datapath and the ALU.
  The datapath drives the operands and opcode through modport dp,
  the ALU returns the result and its flags through modport alu.
*/

`timescale 1ns/10ps

interface alu_if;
	import cpu_types_pkg::*;

	// operands, a also supplies the shift amount
	word_t port_a;
	word_t port_b;

	// operation select
	aluop_t alu_op;

	// combinational outputs of the alu
	word_t result;
	logic negative;
	logic zero;
	logic overflow;

	// the alu itself only consumes operands and produces result and flags
	modport alu (
		input port_a, port_b, alu_op,
		output result, negative, zero, overflow
	);

	// the datapath side sets up the operation and observes the outcome
	modport dp (
		output port_a, port_b, alu_op,
		input result, negative, zero, overflow
	);

endinterface

// ==== source/register_file_if.sv ====
/*
  Bundle between the datapath and the register file.
  One write port and two read ports, no handshake, plain levels only.
  The register file drives the read data, the datapath drives the rest.
*/

`timescale 1ns/10ps

interface register_file_if;
	import cpu_types_pkg::*;

	// write port, acts on the rising clock edge while wen is high
	logic wen;
	regbits_t wsel;
	word_t wdat;

	// two independent read ports
	regbits_t rsel1;
	regbits_t rsel2;
	word_t rdat1;
	word_t rdat2;

	// register file view
	modport rf (
		input wen, wsel, wdat, rsel1, rsel2,
		output rdat1, rdat2
	);

	// datapath view, selects registers and supplies write data
	modport dp (
		output wen, wsel, wdat, rsel1, rsel2,
		input rdat1, rdat2
	);

endinterface

// ==== source/alu.sv ====
/*
  Combinational ALU with ten operations and three status flags.
  Result and flags follow the operands within the same cycle.
  Overflow applies one sign rule to both add and subtract.
*/

`timescale 1ns/10ps

module alu (
	alu_if.alu aluif
);
	import cpu_types_pkg::*;

	// negative is just the sign bit of whatever the alu produced
	assign aluif.negative = aluif.result[word_w-1];

	// zero is high when no result bit is set
	assign aluif.zero = (aluif.result == '0);

	// overflow only means something for add and subtract
	always_comb begin
		aluif.overflow = 1'b0;
		if ((aluif.alu_op == alu_add) || (aluif.alu_op == alu_sub)) begin
			// operands of equal sign whose result flips away from b's sign
			// note that for subtract this is not true signed overflow
			if (aluif.port_a[word_w-1] == aluif.port_b[word_w-1]) begin
				if (aluif.result[word_w-1] == ~aluif.port_b[word_w-1]) begin
					aluif.overflow = 1'b1;
				end
			end
		end
	end

	// main operation select
	always_comb begin
		// unused opcodes produce a zero result
		aluif.result = '0;
		case (aluif.alu_op)
			// shifts move b, the amount comes from the low bits of a
			alu_sll: begin
				aluif.result = aluif.port_b << aluif.port_a[shamt_w-1:0];
			end
			alu_srl: begin
				aluif.result = aluif.port_b >> aluif.port_a[shamt_w-1:0];
			end
			// add is b plus a, subtract is a minus b
			alu_add: begin
				aluif.result = word_t'($signed(aluif.port_b) + $signed(aluif.port_a));
			end
			alu_sub: begin
				aluif.result = word_t'($signed(aluif.port_a) - $signed(aluif.port_b));
			end
			alu_and: begin
				aluif.result = aluif.port_a & aluif.port_b;
			end
			alu_or: begin
				aluif.result = aluif.port_a | aluif.port_b;
			end
			alu_xor: begin
				aluif.result = aluif.port_a ^ aluif.port_b;
			end
			alu_nor: begin
				aluif.result = ~(aluif.port_a | aluif.port_b);
			end
			// set-less-than yields a single 1 or 0 in bit zero
			alu_slt: begin
				if ($signed(aluif.port_a) < $signed(aluif.port_b)) begin
					aluif.result = word_t'(1);
				end
			end
			alu_sltu: begin
				if (aluif.port_a < aluif.port_b) begin
					aluif.result = word_t'(1);
				end
			end
			default: begin
				aluif.result = '0;
			end
		endcase
	end

endmodule

// ==== source/register_file.sv ====
/*
  Register file of 32 words with one write and two read ports.
  Register zero is hardwired to zero, writes to it are dropped.
  Writes land on the rising clock edge and are readable the cycle after.
*/

`timescale 1ns/10ps

module register_file (
	input logic CLK,
	input logic arst_n,
	register_file_if.rf rfif
);
	import cpu_types_pkg::*;

	// storage, one word per register number
	word_t regs [2**reg_w];

	// asynchronous clear of every register, then plain synchronous writes
	always_ff @(posedge CLK, negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (rfif.wen && (rfif.wsel != '0)) begin
			regs[rfif.wsel] <= rfif.wdat;
		end
	end

	// read ports have no bypass from the write port
	// a value written this cycle only shows up after the edge
	// register zero reads zero because its slot is cleared and never written
	assign rfif.rdat1 = regs[rfif.rsel1];
	assign rfif.rdat2 = regs[rfif.rsel2];

	// the datapath must never write with an undefined target or value
	a_write_known: assert property (
		@(posedge CLK) disable iff (!arst_n)
		rfif.wen |-> !$isunknown({rfif.wsel, rfif.wdat})
	);

	// the zero slot must survive any sequence of writes
	a_reg_zero: assert property (
		@(posedge CLK) disable iff (!arst_n)
		regs[0] == '0
	);

endmodule

// ==== source/alu_datapath.sv ====
/*
  Execute datapath top level, register file feeding the ALU.
  Operand b comes from the second read port or from the immediate.
  The write port stores either the ALU result or an external word.
*/

`timescale 1ns/10ps

module alu_datapath (
	input logic CLK,
	input logic arst_n,
	// write port control
	input logic wen,
	input logic wsrc,
	input cpu_types_pkg::regbits_t wsel,
	input cpu_types_pkg::word_t ext_wdat,
	// read selects and operand b source
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	input logic use_imm,
	input cpu_types_pkg::word_t imm,
	input cpu_types_pkg::aluop_t alu_op,
	// alu outputs, combinational from the inputs above
	output cpu_types_pkg::word_t result,
	output logic negative,
	output logic zero,
	output logic overflow
);
	import cpu_types_pkg::*;

	alu_if aluif ();
	register_file_if rfif ();

	register_file rf0 (
		.CLK(CLK),
		.arst_n(arst_n),
		.rfif(rfif.rf)
	);

	alu alu0 (
		.aluif(aluif.alu)
	);

	// read selects go straight to the register file
	assign rfif.rsel1 = rsel1;
	assign rfif.rsel2 = rsel2;

	// a always comes from the first read port
	assign aluif.port_a = rfif.rdat1;
	// b takes the immediate when requested
	assign aluif.port_b = use_imm ? imm : rfif.rdat2;
	assign aluif.alu_op = alu_op;

	// write-back, wsrc high loads the external word for preloading
	assign rfif.wen = wen;
	assign rfif.wsel = wsel;
	assign rfif.wdat = wsrc ? ext_wdat : aluif.result;

	assign result = aluif.result;
	assign negative = aluif.negative;
	assign zero = aluif.zero;
	assign overflow = aluif.overflow;

	// only add and subtract are allowed to raise overflow
	a_ovf_arith_only: assert property (
		@(posedge CLK) disable iff (!arst_n)
		overflow |-> ((alu_op == alu_add) || (alu_op == alu_sub))
	);

	// compare operations produce a single bit in a full word
	a_slt_bool: assert property (
		@(posedge CLK) disable iff (!arst_n)
		((alu_op == alu_slt) || (alu_op == alu_sltu)) |-> (result[word_w-1:1] == '0)
	);

endmodule

// ==== verif/alu_datapath_tb.sv ====
/*
  Testbench for the execute datapath.
  Loads verif/alu_datapath_input.txt, applies one line per clock cycle and
  checks the ALU result and flags one ns before the following rising edge.
  Run from the project root so the stimulus path resolves.
*/

`timescale 1ns/10ps

module alu_datapath_tb;
	import cpu_types_pkg::*;

	logic CLK;
	logic arst_n;
	logic wen;
	logic wsrc;
	regbits_t wsel;
	word_t ext_wdat;
	regbits_t rsel1;
	regbits_t rsel2;
	logic use_imm;
	word_t imm;
	aluop_t alu_op;
	word_t result;
	logic negative;
	logic zero;
	logic overflow;

	// data lines are held in memory first so the watchdog knows the run length
	string lines [$];
	bit lines_loaded;

	alu_datapath dut0 (
		.CLK(CLK),
		.arst_n(arst_n),
		.wen(wen),
		.wsrc(wsrc),
		.wsel(wsel),
		.ext_wdat(ext_wdat),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.use_imm(use_imm),
		.imm(imm),
		.alu_op(alu_op),
		.result(result),
		.negative(negative),
		.zero(zero),
		.overflow(overflow)
	);

	// 8 ns clock period
	always #4 CLK = ~CLK;

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("ERR time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR time=%0t signal=%s expected=%b actual=%b",
				$time, name, expected, actual);
			stop_run();
		end
	endtask

	// keeps every line that is neither blank nor a comment starting with '#'
	task automatic load_lines();
		int fd;
		string line;
		fd = $fopen("verif/alu_datapath_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verif/alu_datapath_input.txt");
			stop_run();
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ((line.len() > 1) && (line.getc(0) != 8'h23)) begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	// called 1 ns after a rising edge, returns 1 ns before the next one
	task automatic run_line(input string line, input int num);
		logic [31:0] f [13];
		int n;
		n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
			f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
		if (n != 13) begin
			$display("stimulus line %0d holds %0d fields instead of 13", num, n);
			stop_run();
		end else begin
			wen = f[0][0];
			wsrc = f[1][0];
			wsel = regbits_t'(f[2]);
			ext_wdat = f[3];
			if (wen && wsrc) begin
				// pure write, the read side is unchecked so it gets random values
				rsel1 = regbits_t'($urandom);
				rsel2 = regbits_t'($urandom);
				use_imm = ($urandom_range(1, 0) != 0);
				imm = $urandom;
				alu_op = aluop_t'(4'($urandom_range(9, 0)));
			end else begin
				rsel1 = regbits_t'(f[4]);
				rsel2 = regbits_t'(f[5]);
				use_imm = f[6][0];
				imm = f[7];
				alu_op = aluop_t'(f[8][3:0]);
			end
			#6;
			if (!(wen && wsrc)) begin
				check_word("result", f[9], result);
				check_flag("negative", f[10][0], negative);
				check_flag("zero", f[11][0], zero);
				check_flag("overflow", f[12][0], overflow);
			end
		end
	endtask

	initial begin
		void'($urandom(53));
		CLK = 1'b0;
		arst_n = 1'b0;
		wen = 1'b0;
		wsrc = 1'b0;
		wsel = '0;
		ext_wdat = '0;
		rsel1 = '0;
		rsel2 = '0;
		use_imm = 1'b0;
		imm = '0;
		alu_op = alu_or;
		load_lines();
		if (lines.size() == 0) begin
			$display("the stimulus file holds no data lines");
			stop_run();
		end else begin
			lines_loaded = 1'b1;
			// two cycles of reset, inputs then move 1 ns after each edge
			repeat (2) @(posedge CLK);
			#1;
			arst_n = 1'b1;
			foreach (lines[i]) begin
				run_line(lines[i], i + 1);
				@(posedge CLK);
				#1;
			end
			$display("Everything OK");
			$finish;
		end
	end

	// one cycle per data line plus ten for reset and slack
	initial begin
		wait (lines_loaded);
		#((lines.size() + 10) * 8);
		$display("timeout after %0d clock cycles, the stimulus never finished",
			lines.size() + 10);
		stop_run();
	end

endmodule

// ==== verif/alu_datapath_input.txt ====
# hex fields: wen wsrc wsel ext_wdat rsel1 rsel2 use_imm imm alu_op exp_result exp_neg exp_zero exp_ovf
# lines with wen=1 and wsrc=1 are pure writes, their read and expected fields are ignored
0 0 00 00000000 03 07 0 00000000 5 00000000 0 1 0
0 0 00 00000000 1f 1e 0 00000000 5 00000000 0 1 0
1 1 00 deadbeef 00 00 0 00000000 0 00000000 0 0 0
0 0 00 00000000 00 00 0 00000000 5 00000000 0 1 0
1 1 01 000000ff 00 00 0 00000000 0 00000000 0 0 0
1 1 02 0f0f0f0f 00 00 0 00000000 0 00000000 0 0 0
1 1 03 ffffffff 00 00 0 00000000 0 00000000 0 0 0
1 1 04 00000001 00 00 0 00000000 0 00000000 0 0 0
1 1 05 7fffffff 00 00 0 00000000 0 00000000 0 0 0
1 1 06 80000000 00 00 0 00000000 0 00000000 0 0 0
1 1 07 0000001f 00 00 0 00000000 0 00000000 0 0 0
1 1 08 12345678 00 00 0 00000000 0 00000000 0 0 0
0 0 00 00000000 01 00 0 00000000 5 000000ff 0 0 0
0 0 00 00000000 03 00 0 00000000 5 ffffffff 1 0 0
0 0 00 00000000 01 02 0 00000000 4 0000000f 0 0 0
0 0 00 00000000 01 02 0 00000000 5 0f0f0fff 0 0 0
0 0 00 00000000 01 02 0 00000000 6 0f0f0ff0 0 0 0
0 0 00 00000000 00 03 0 00000000 7 00000000 0 1 0
0 0 00 00000000 03 08 0 00000000 4 12345678 0 0 0
0 0 00 00000000 05 04 0 00000000 2 80000000 1 0 1
0 0 00 00000000 03 04 0 00000000 2 00000000 0 1 0
0 0 00 00000000 05 05 0 00000000 2 fffffffe 1 0 1
0 0 00 00000000 01 02 0 00000000 2 0f0f100e 0 0 0
0 0 00 00000000 04 03 0 00000000 3 00000002 0 0 0
0 0 00 00000000 02 01 0 00000000 3 0f0f0e10 0 0 0
0 0 00 00000000 01 02 0 00000000 3 f0f0f1f0 1 0 1
0 0 00 00000000 06 04 0 00000000 3 7fffffff 0 0 0
0 0 00 00000000 00 08 0 00000000 0 12345678 0 0 0
0 0 00 00000000 07 04 0 00000000 0 80000000 1 0 0
0 0 00 00000000 07 03 0 00000000 1 00000001 0 0 0
0 0 00 00000000 04 06 0 00000000 1 40000000 0 0 0
0 0 00 00000000 02 04 0 00000000 0 00008000 0 0 0
0 0 00 00000000 03 04 0 00000000 8 00000001 0 0 0
0 0 00 00000000 03 04 0 00000000 9 00000000 0 1 0
0 0 00 00000000 06 05 0 00000000 8 00000001 0 0 0
0 0 00 00000000 06 05 0 00000000 9 00000000 0 1 0
0 0 00 00000000 01 00 1 00000100 2 000001ff 0 0 0
0 0 00 00000000 00 03 1 a5a5a5a5 5 a5a5a5a5 1 0 0
0 0 00 00000000 04 05 1 00000001 3 00000000 0 1 0
0 0 00 00000000 03 03 1 00000000 8 00000001 0 0 0
1 0 09 00000000 05 04 0 00000000 2 80000000 1 0 1
1 0 0a 00000000 02 00 1 000000f0 6 0f0f0fff 0 0 0
0 0 00 00000000 09 00 0 00000000 5 80000000 1 0 0
0 0 00 00000000 0a 00 0 00000000 5 0f0f0fff 0 0 0

// ==== verilog.f ====
source/cpu_types_pkg.sv
source/alu_if.sv
source/register_file_if.sv
source/alu.sv
source/register_file.sv
source/alu_datapath.sv
verif/alu_datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
# the exit status is the simulator's, nonzero when the testbench stops on $fatal
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/10ps --top-module alu_datapath_tb \
	-f verilog.f -o alu_datapath_tb_sim &&
./obj_dir/alu_datapath_tb_sim || { echo "simulation did not pass"; exit 1; }
